//--- verilog/demosaic_settings.svh
`ifndef DEMOSAIC_SETTINGS_SVH
`define DEMOSAIC_SETTINGS_SVH

// Frame geometry, small for simulation
`define DEMOSAIC_WIDTH 8
`define DEMOSAIC_HEIGHT 6
`define DEMOSAIC_SAMPLE_BITS 8

// Two rows buffered before the first position comes out
`define DEMOSAIC_LEAD_IN (`DEMOSAIC_WIDTH * 2)

// Frame plus two padding rows
`define DEMOSAIC_TOTAL (`DEMOSAIC_WIDTH * (`DEMOSAIC_HEIGHT + 2))

`endif

//--- verilog/pixelPkg.sv
`include "demosaic_settings.svh"

package pixelPkg;

	// One raw Bayer sample, also used for one colour channel
	typedef logic [`DEMOSAIC_SAMPLE_BITS-1:0] sample_t;

	// Sum of two samples, one bit of headroom for the green average
	typedef logic [`DEMOSAIC_SAMPLE_BITS:0] sampleSum_t;

endpackage

//--- verilog/rasterPkg.sv
`include "demosaic_settings.svh"

package rasterPkg;

	// Pixel position inside the frame
	typedef logic [15:0] coord_t;

	// Index into the frame plus padding stream
	typedef logic [31:0] sampleCount_t;

	// FILL while the row buffer is primed, SCAN while positions come out
	typedef enum logic {
		FILL,
		SCAN
	} seqState_t;

endpackage

//--- verilog/rasterSequencer.sv
`timescale 1ns/1ps
`include "demosaic_settings.svh"

module rasterSequencer (
	input logic clk,
	input logic reset,
	input logic pixelValid,
	output logic posValid,
	output logic blank,
	output logic lastSample,
	output rasterPkg::coord_t xCur,
	output rasterPkg::coord_t yCur
);

	localparam rasterPkg::sampleCount_t FRAME_SAMPLES =
		rasterPkg::sampleCount_t'(`DEMOSAIC_WIDTH * `DEMOSAIC_HEIGHT);
	localparam rasterPkg::sampleCount_t LEAD_IN =
		rasterPkg::sampleCount_t'(`DEMOSAIC_LEAD_IN);
	localparam rasterPkg::sampleCount_t TOTAL =
		rasterPkg::sampleCount_t'(`DEMOSAIC_TOTAL);
	localparam rasterPkg::coord_t LAST_X = rasterPkg::coord_t'(`DEMOSAIC_WIDTH - 1);
	localparam rasterPkg::coord_t LAST_Y = rasterPkg::coord_t'(`DEMOSAIC_HEIGHT - 1);

	rasterPkg::sampleCount_t count;
	rasterPkg::seqState_t state;

	// Flags for the sample currently on the input
	assign posValid = (state == rasterPkg::SCAN);
	assign blank = (count >= FRAME_SAMPLES);
	assign lastSample = (count == TOTAL - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			state <= rasterPkg::FILL;
			xCur <= '0;
			yCur <= '0;
		end else if (pixelValid) begin
			// Wrap straight into the next frame
			if (lastSample) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end

			case (state)
				rasterPkg::FILL: begin
					if (count == LEAD_IN - 1) begin
						state <= rasterPkg::SCAN;
					end
				end
				rasterPkg::SCAN: begin
					if (lastSample) begin
						state <= rasterPkg::FILL;
					end
					// Raster walk, ends back at the origin after the last position
					if (xCur == LAST_X) begin
						xCur <= '0;
						if (yCur == LAST_Y) begin
							yCur <= '0;
						end else begin
							yCur <= yCur + 1'b1;
						end
					end else begin
						xCur <= xCur + 1'b1;
					end
				end
				default: begin
					state <= rasterPkg::FILL;
				end
			endcase
		end
	end

endmodule

//--- verilog/rowDelayBuffer.sv
`timescale 1ns/1ps
`include "demosaic_settings.svh"

module rowDelayBuffer (
	input logic clk,
	input logic reset,
	input logic pixelValid,
	input logic blank,
	input pixelPkg::sample_t pixel,
	output pixelPkg::sample_t nearTap,
	output pixelPkg::sample_t farTap
);

	localparam int DEPTH = 2 * `DEMOSAIC_WIDTH;
	localparam int PTR_BITS = $clog2(DEPTH);
	localparam logic [PTR_BITS-1:0] ROW_OFFSET = PTR_BITS'(`DEMOSAIC_WIDTH);
	localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);

	pixelPkg::sample_t rowMem [DEPTH];
	logic [PTR_BITS-1:0] wrPtr;
	logic [PTR_BITS-1:0] nearPtr;

	// One row behind the write slot, modulo the depth
	always_comb begin
		if (wrPtr >= ROW_OFFSET) begin
			nearPtr = wrPtr - ROW_OFFSET;
		end else begin
			nearPtr = wrPtr + ROW_OFFSET;
		end
	end

	// Slot about to be overwritten holds the sample two rows back
	assign farTap = rowMem[wrPtr];
	assign nearTap = rowMem[nearPtr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				rowMem[i] <= '0;
			end
		end else if (pixelValid) begin
			// Padding rows enter as zero
			rowMem[wrPtr] <= blank ? '0 : pixel;
			if (wrPtr == LAST_PTR) begin
				wrPtr <= '0;
			end else begin
				wrPtr <= wrPtr + 1'b1;
			end
		end
	end

endmodule

//--- verilog/bayerNeighborInterp.sv
`timescale 1ns/1ps

module bayerNeighborInterp (
	input logic clk,
	input logic reset,
	input logic pixelValid,
	input logic posValid,
	input logic lastSample,
	input pixelPkg::sample_t nearTap,
	input pixelPkg::sample_t farTap,
	input rasterPkg::coord_t xCur,
	input rasterPkg::coord_t yCur,
	output pixelPkg::sample_t red,
	output pixelPkg::sample_t green,
	output pixelPkg::sample_t blue,
	output rasterPkg::coord_t xPos,
	output rasterPkg::coord_t yPos,
	output logic outValid,
	output logic frameDone
);

	// Taps from the previous accepted sample
	pixelPkg::sample_t prevNear;
	pixelPkg::sample_t prevFar;

	pixelPkg::sample_t redNext;
	pixelPkg::sample_t blueNext;
	pixelPkg::sample_t greenA;
	pixelPkg::sample_t greenB;
	pixelPkg::sample_t greenNext;
	pixelPkg::sampleSum_t greenSum;

	// A = farTap, B = prevFar, C = nearTap, D = prevNear
	always_comb begin
		case ({yCur[0], xCur[0]})
			2'b00: begin
				redNext = nearTap;
				greenA = prevNear;
				greenB = farTap;
				blueNext = prevFar;
			end
			2'b01: begin
				redNext = prevNear;
				greenA = nearTap;
				greenB = prevFar;
				blueNext = farTap;
			end
			2'b10: begin
				redNext = farTap;
				greenA = prevFar;
				greenB = nearTap;
				blueNext = prevNear;
			end
			default: begin
				redNext = prevFar;
				greenA = farTap;
				greenB = prevNear;
				blueNext = nearTap;
			end
		endcase
	end

	// Remainder is dropped
	assign greenSum = pixelPkg::sampleSum_t'(greenA) + pixelPkg::sampleSum_t'(greenB);
	assign greenNext = pixelPkg::sample_t'(greenSum >> 1);

	always_ff @(posedge clk) begin
		if (pixelValid) begin
			prevNear <= nearTap;
			prevFar <= farTap;
			red <= redNext;
			green <= greenNext;
			blue <= blueNext;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			xPos <= '0;
			yPos <= '0;
			outValid <= 1'b0;
			frameDone <= 1'b0;
		end else if (pixelValid) begin
			xPos <= xCur;
			yPos <= yCur;
			outValid <= posValid;
			frameDone <= lastSample;
		end else begin
			// Single-cycle strobes
			outValid <= 1'b0;
			frameDone <= 1'b0;
		end
	end

endmodule

//--- verilog/demosaicNeighbor.sv
`timescale 1ns/1ps

module demosaicNeighbor (
	input logic clk,
	input logic reset,
	input pixelPkg::sample_t pixel,
	input logic pixelValid,
	output pixelPkg::sample_t red,
	output pixelPkg::sample_t green,
	output pixelPkg::sample_t blue,
	output rasterPkg::coord_t xPos,
	output rasterPkg::coord_t yPos,
	output logic outValid,
	output logic frameDone
);

	logic posValid;
	logic blank;
	logic lastSample;
	rasterPkg::coord_t xCur;
	rasterPkg::coord_t yCur;
	pixelPkg::sample_t nearTap;
	pixelPkg::sample_t farTap;

	rasterSequencer u_rasterSequencer (
		.clk(clk),
		.reset(reset),
		.pixelValid(pixelValid),
		.posValid(posValid),
		.blank(blank),
		.lastSample(lastSample),
		.xCur(xCur),
		.yCur(yCur)
	);

	rowDelayBuffer u_rowDelayBuffer (
		.clk(clk),
		.reset(reset),
		.pixelValid(pixelValid),
		.blank(blank),
		.pixel(pixel),
		.nearTap(nearTap),
		.farTap(farTap)
	);

	bayerNeighborInterp u_bayerNeighborInterp (
		.clk(clk),
		.reset(reset),
		.pixelValid(pixelValid),
		.posValid(posValid),
		.lastSample(lastSample),
		.nearTap(nearTap),
		.farTap(farTap),
		.xCur(xCur),
		.yCur(yCur),
		.red(red),
		.green(green),
		.blue(blue),
		.xPos(xPos),
		.yPos(yPos),
		.outValid(outValid),
		.frameDone(frameDone)
	);

endmodule

//--- verif/demosaicNeighborTb.sv
`timescale 1ns/1ps
`include "demosaic_settings.svh"

module demosaicNeighborTb;

	localparam int WIDTH = `DEMOSAIC_WIDTH;
	localparam int FRAME_SAMPLES = `DEMOSAIC_WIDTH * `DEMOSAIC_HEIGHT;
	localparam int LEAD_IN = `DEMOSAIC_LEAD_IN;
	localparam int TOTAL = `DEMOSAIC_TOTAL;
	localparam int FRAMES_PER_TEST = 2;
	localparam int WAIT_LIMIT = 64;
	localparam pixelPkg::sample_t JUNK = pixelPkg::sample_t'(8'hc3);

	logic clk;
	logic reset;
	pixelPkg::sample_t pixel;
	logic pixelValid;
	pixelPkg::sample_t red;
	pixelPkg::sample_t green;
	pixelPkg::sample_t blue;
	rasterPkg::coord_t xPos;
	rasterPkg::coord_t yPos;
	logic outValid;
	logic frameDone;

	// Expected response of the sample now on the inputs
	logic expPos;
	logic expDone;
	rasterPkg::coord_t expX;
	rasterPkg::coord_t expY;
	pixelPkg::sample_t expRed;
	pixelPkg::sample_t expGreen;
	pixelPkg::sample_t expBlue;

	// Expected response of the sample taken at the last rising edge
	logic heldPos;
	logic heldDone;
	rasterPkg::coord_t heldX;
	rasterPkg::coord_t heldY;
	pixelPkg::sample_t heldRed;
	pixelPkg::sample_t heldGreen;
	pixelPkg::sample_t heldBlue;

	int errorCount = 0;
	int outCount = 0;
	int doneCount = 0;
	int passCount = 0;
	int failCount = 0;
	logic [31:0] randState = 32'h5fa5;
	pixelPkg::sample_t frameData [FRAME_SAMPLES];

	demosaicNeighbor u_demosaicNeighbor (
		.clk(clk),
		.reset(reset),
		.pixel(pixel),
		.pixelValid(pixelValid),
		.red(red),
		.green(green),
		.blue(blue),
		.xPos(xPos),
		.yPos(yPos),
		.outValid(outValid),
		.frameDone(frameDone)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] nextRandom();
		randState = randState * 32'd1664525 + 32'd1013904223;
		return randState;
	endfunction

	// Buffered value for a stream index
	// Padding and earlier frames read as zero
	function automatic int writtenValue(input int idx);
		if (idx < 0 || idx >= FRAME_SAMPLES) begin
			return 0;
		end
		return int'(frameData[idx]);
	endfunction

	task automatic reportValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
		errorCount++;
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (outValid !== heldPos) begin
				reportValue("outValid", heldPos, outValid);
			end
			if (frameDone !== heldDone) begin
				reportValue("frameDone", heldDone, frameDone);
			end
			if (outValid === 1'b1) begin
				outCount++;
			end
			if (heldPos && outValid === 1'b1) begin
				if (xPos !== heldX) begin
					reportValue("xPos", heldX, xPos);
				end
				if (yPos !== heldY) begin
					reportValue("yPos", heldY, yPos);
				end
				if (red !== heldRed) begin
					reportValue("red", heldRed, red);
				end
				if (green !== heldGreen) begin
					reportValue("green", heldGreen, green);
				end
				if (blue !== heldBlue) begin
					reportValue("blue", heldBlue, blue);
				end
			end
			if (frameDone === 1'b1) begin
				doneCount++;
			end
		end
		heldPos = pixelValid && expPos;
		heldDone = pixelValid && expDone;
		heldX = expX;
		heldY = expY;
		heldRed = expRed;
		heldGreen = expGreen;
		heldBlue = expBlue;
	end

	task automatic buildFrame(input logic [8*16-1:0] mode, input pixelPkg::sample_t value,
		input int frameNo, output logic known);
		logic [31:0] rnd;
		known = 1'b1;
		for (int i = 0; i < FRAME_SAMPLES; i++) begin
			if (mode == "ramp") begin
				frameData[i] = pixelPkg::sample_t'(value + i + frameNo * FRAME_SAMPLES);
			end else if (mode == "constant") begin
				frameData[i] = (frameNo == 0) ? value : ~value;
			end else if (mode == "random") begin
				rnd = nextRandom();
				frameData[i] = pixelPkg::sample_t'(rnd[23:16]) ^ value;
			end else begin
				known = 1'b0;
			end
		end
	endtask

	task automatic driveIdle();
		pixel = JUNK;
		pixelValid = 1'b0;
		expPos = 1'b0;
		expDone = 1'b0;
		@(posedge clk);
		#1;
	endtask

	// Drives stream index k with its expected 2x2 phase-table result
	task automatic driveSample(input int k);
		int p;
		int x;
		int y;
		int a;
		int b;
		int c;
		int d;
		int rv;
		int gv;
		int bv;
		p = k - LEAD_IN;
		x = (p >= 0) ? p % WIDTH : 0;
		y = (p >= 0) ? p / WIDTH : 0;
		a = writtenValue(k - 2 * WIDTH);
		b = writtenValue(k - 1 - 2 * WIDTH);
		c = writtenValue(k - WIDTH);
		d = writtenValue(k - 1 - WIDTH);
		case ({y[0], x[0]})
			2'b00: begin
				rv = c;
				gv = (d + a) / 2;
				bv = b;
			end
			2'b01: begin
				rv = d;
				gv = (c + b) / 2;
				bv = a;
			end
			2'b10: begin
				rv = a;
				gv = (b + c) / 2;
				bv = d;
			end
			default: begin
				rv = b;
				gv = (a + d) / 2;
				bv = c;
			end
		endcase
		pixel = (k < FRAME_SAMPLES) ? frameData[k] : JUNK;
		pixelValid = 1'b1;
		expPos = (k >= LEAD_IN);
		expDone = (k == TOTAL - 1);
		expX = rasterPkg::coord_t'(x);
		expY = rasterPkg::coord_t'(y);
		expRed = pixelPkg::sample_t'(rv);
		expGreen = pixelPkg::sample_t'(gv);
		expBlue = pixelPkg::sample_t'(bv);
		@(posedge clk);
		#1;
	endtask

	task automatic driveFrame(input int gap);
		logic [31:0] rnd;
		for (int k = 0; k < TOTAL; k++) begin
			if (gap != 0) begin
				rnd = nextRandom();
				repeat (rnd[29:28] % 3) begin
					driveIdle();
				end
			end
			driveSample(k);
		end
	endtask

	task automatic waitForFrames(input int doneTarget, input int outTarget,
		output logic finished);
		int cycles;
		cycles = 0;
		while ((doneCount < doneTarget || outCount < outTarget) && cycles < WAIT_LIMIT) begin
			driveIdle();
			cycles++;
		end
		finished = (doneCount >= doneTarget && outCount >= outTarget);
	endtask

	initial begin
		int fd;
		int fields;
		int gap;
		int testErrors;
		int doneBase;
		int outBase;
		logic [8*80-1:0] line;
		logic [8*32-1:0] testName;
		logic [8*16-1:0] mode;
		pixelPkg::sample_t value;
		logic known;
		logic finished;
		clk = 1'b0;
		reset = 1'b1;
		pixel = '0;
		pixelValid = 1'b0;
		expPos = 1'b0;
		expDone = 1'b0;
		expX = '0;
		expY = '0;
		expRed = '0;
		expGreen = '0;
		expBlue = '0;
		heldPos = 1'b0;
		heldDone = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		// Strobes stay low with no input after reset
		repeat (4) driveIdle();

		fd = $fopen("verif/demosaicNeighborTests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file verif/demosaicNeighborTests.txt");
			failCount++;
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				fields = $fgets(line, fd);
				fields = $sscanf(line, "%s %s %h %d", testName, mode, value, gap);
				if (fields == 4 && testName != "#") begin
					testErrors = errorCount;
					doneBase = doneCount;
					outBase = outCount;
					finished = 1'b0;
					buildFrame(mode, value, 0, known);
					if (!known) begin
						$display("Test %0s has an unknown fill mode %0s", testName, mode);
					end else begin
						// Frames follow each other with no idle cycle
						for (int f = 0; f < FRAMES_PER_TEST; f++) begin
							if (f > 0) begin
								buildFrame(mode, value, f, known);
							end
							driveFrame(gap);
						end
						waitForFrames(doneBase + FRAMES_PER_TEST,
							outBase + FRAMES_PER_TEST * FRAME_SAMPLES, finished);
						if (!finished) begin
							$display("Test %0s timed out waiting for outValid and frameDone",
								testName);
						end else begin
							if (outCount - outBase != FRAMES_PER_TEST * FRAME_SAMPLES) begin
								reportValue("outValid pulses", FRAMES_PER_TEST * FRAME_SAMPLES,
									outCount - outBase);
							end
							if (doneCount - doneBase != FRAMES_PER_TEST) begin
								reportValue("frameDone pulses", FRAMES_PER_TEST,
									doneCount - doneBase);
							end
						end
					end
					if (known && finished && errorCount == testErrors) begin
						$display("PASS %0s", testName);
						passCount++;
					end else begin
						$display("FAIL %0s", testName);
						failCount++;
					end
				end
			end
			$fclose(fd);
		end

		$display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
		if (failCount == 0 && errorCount == 0 && passCount > 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- demosaicNeighbor.f
+incdir+verilog
verilog/pixelPkg.sv
verilog/rasterPkg.sv
verilog/rasterSequencer.sv
verilog/rowDelayBuffer.sv
verilog/bayerNeighborInterp.sv
verilog/demosaicNeighbor.sv
verif/demosaicNeighborTb.sv

//--- verif/demosaicNeighborTests.txt
# Columns: test name, fill mode, fill value (hex), idle gaps (0 or 1)
# Fill mode is ramp, constant or random; random XORs the value into the LCG output
rampFromZero ramp 00 0
rampFromMid ramp 80 0
rampWrapping ramp f0 0
rampOdd ramp 01 0
constantZero constant 00 0
constantFull constant ff 0
constantAlt constant 55 0
constantOdd constant 7f 0
constantLow constant 01 0
randomPlain random 00 0
randomMaskA random a5 0
randomMaskB random 3c 0
randomMaskC random ff 0
randomMaskD random 81 0
rampGapZero ramp 00 1
rampGapHigh ramp c0 1
constantGapFull constant ff 1
constantGapAlt constant aa 1
constantGapLow constant 03 1
randomGapPlain random 00 1
randomGapMask random 5a 1
randomGapMaskB random e7 1
rampAfterGaps ramp 20 0
randomAfterGaps random 11 0
constantAfterGaps constant 80 0
rampFinal ramp 7e 1
